/* source/burst_pkg.sv */
// burst writer shared definitions
package burst_pkg;

  localparam int DATA_WIDTH     = 16;                        // memory word width
  localparam int FIFO_DEPTH_LOG = 4;                         // 16 ram entries
  localparam int FIFO_WORDS     = (1 << FIFO_DEPTH_LOG) + 1; // ram plus output register
  localparam int FILL_WIDTH     = FIFO_DEPTH_LOG + 1;        // holds 0..FIFO_WORDS
  localparam int ADDR_WIDTH     = 12;                        // word address
  localparam int BURST_LEN      = 8;                         // max words per command
  localparam int LEN_WIDTH      = 4;                         // holds 1..BURST_LEN

  // sequencer states
  typedef enum logic [1:0] {
    st_idle, // waiting for enough data
    st_cmd,  // one cycle, command out
    st_data  // popping words to memory
  } seq_state_e;

  // memory write command, one per burst
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr; // first word address
    logic [LEN_WIDTH-1:0]  len;  // words in burst
  } mem_cmd_t;

  // fifo fill and error flags seen from outside
  typedef struct packed {
    logic [FILL_WIDTH-1:0] num_in_fifo; // all held words
    logic                  nempty;      // output word valid
    logic                  half_full;   // ram at least half full
    logic                  over;        // write dropped last cycle
  } fifo_status_t;

endpackage

/* source/fifo_same_clock_fill.sv */
// same clock fifo with fill level
`timescale 1ns/1ps

module fifo_same_clock_fill #(
  parameter int data_width = burst_pkg::DATA_WIDTH,
  parameter int depth_log  = burst_pkg::FIFO_DEPTH_LOG
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clear,       // sync flush of everything
  input  logic                  we,
  input  logic                  re,          // only while nempty
  input  logic [data_width-1:0] data_in,
  output logic [data_width-1:0] data_out,
  output logic                  nempty,
  output logic                  half_full,
  output logic                  over,
  output logic [depth_log:0]    num_in_fifo
);

  logic [data_width-1:0] ram [0:(1 << depth_log)-1];
  logic [data_width-1:0] inreg;      // input stage
  logic [data_width-1:0] outreg;     // first word fall through
  logic [depth_log-1:0]  wa;         // ram write pointer
  logic [depth_log-1:0]  ra;         // ram read pointer
  logic [depth_log:0]    fill;       // words in ram only
  logic [depth_log:0]    next_fill;
  logic [depth_log:0]    fifo_fill;  // inreg + ram + outreg
  logic                  wem;        // inreg holds a word for ram
  logic                  rem;        // ram to outreg transfer
  logic                  ram_nempty;
  logic                  out_full;   // outreg holds a word
  logic                  fifo_full;
  logic                  accept;     // write taken

  assign fifo_full = (fifo_fill == ((1 << depth_log) + 1));
  assign accept    = we && (!fifo_full || re); // a read frees one slot
  assign rem       = ram_nempty && (re || !out_full); // prefetch when outreg free

  always_comb begin
    next_fill = fill;
    if (wem && !rem)
      next_fill = fill + 1'b1; // write only
    else if (!wem && rem)
      next_fill = fill - 1'b1; // read only
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill       <= '0;
      fifo_fill  <= '0;
      wem        <= 1'b0;
      ram_nempty <= 1'b0;
      wa         <= '0;
      ra         <= '0;
      out_full   <= 1'b0;
      half_full  <= 1'b0;
      over       <= 1'b0;
    end else if (clear) begin
      fill       <= '0;
      fifo_fill  <= '0;
      wem        <= 1'b0;
      ram_nempty <= 1'b0;
      wa         <= '0;
      ra         <= '0;
      out_full   <= 1'b0;
      half_full  <= 1'b0;
      over       <= 1'b0;
    end else begin
      fill       <= next_fill;
      ram_nempty <= (next_fill != '0);
      wem        <= accept;
      if (accept && !re)
        fifo_fill <= fifo_fill + 1'b1;
      else if (!accept && re)
        fifo_fill <= fifo_fill - 1'b1;
      if (wem)
        wa <= wa + 1'b1;
      if (rem)
        ra <= ra + 1'b1;
      if (rem && !re)
        out_full <= 1'b1;  // refilled with nobody reading
      else if (re && !rem)
        out_full <= 1'b0;  // drained with nothing behind
      half_full <= (fill >= (1 << (depth_log - 1))); // lags ram fill by a cycle
      over      <= we && !accept;                    // dropped write
    end
  end

  // data path
  always_ff @(posedge clk) begin
    if (accept)
      inreg <= data_in;
    if (wem)
      ram[wa] <= inreg;
    if (rem)
      outreg <= ram[ra]; // old word when wa == ra
  end

  assign data_out    = outreg;
  assign nempty      = out_full;
  assign num_in_fifo = fifo_fill;

  // reader must honor fall through valid
  a_no_underrun : assert property (@(posedge clk) disable iff (rst)
    re |-> nempty);

  // total count matches the stages and ram never overfills
  a_fill_bound : assert property (@(posedge clk) disable iff (rst)
    (num_in_fifo == fill + out_full + wem) && (fill <= (1 << depth_log)));

endmodule

/* source/burst_counter.sv */
// burst word and address counter
`timescale 1ns/1ps

module burst_counter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            clear,
  input  logic                            load,  // start of burst
  input  logic                            step,  // one word moved
  input  logic [burst_pkg::LEN_WIDTH-1:0] len,
  output logic [burst_pkg::ADDR_WIDTH-1:0] addr, // next burst start
  output logic                            last
);

  logic [burst_pkg::LEN_WIDTH-1:0]  remaining; // words left in burst
  logic [burst_pkg::LEN_WIDTH-1:0]  burst_len; // kept for address advance
  logic [burst_pkg::ADDR_WIDTH-1:0] len_ext;

  assign len_ext = {{(burst_pkg::ADDR_WIDTH - burst_pkg::LEN_WIDTH){1'b0}}, burst_len};
  assign last    = (remaining == 1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      remaining <= '0;
      addr      <= '0;
    end else if (clear) begin
      remaining <= '0;
      addr      <= '0;
    end else if (load) begin
      remaining <= len;
    end else if (step) begin
      remaining <= remaining - 1'b1;
      if (last)
        addr <= addr + len_ext; // wraps at address width
    end
  end

  // length of the active burst
  always_ff @(posedge clk) begin
    if (load)
      burst_len <= len;
  end

  // sequencer never reads past the command length
  a_no_step_idle : assert property (@(posedge clk) disable iff (rst)
    step |-> (remaining != '0));

endmodule

/* source/burst_sequencer.sv */
// burst start and read sequencer
`timescale 1ns/1ps

module burst_sequencer (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             clear,
  input  logic                             flush,      // one cycle request
  input  logic                             drain_en,   // level, gates new bursts
  input  logic [burst_pkg::FILL_WIDTH-1:0] num_in_fifo,
  input  logic                             nempty,
  input  logic                             last,
  input  logic [burst_pkg::ADDR_WIDTH-1:0] addr,
  output logic                             load,
  output logic                             re,
  output logic [burst_pkg::LEN_WIDTH-1:0]  len,
  output logic                             cmd_valid,
  output burst_pkg::mem_cmd_t              cmd,
  output logic                             burst_done
);

  burst_pkg::seq_state_e state;
  burst_pkg::seq_state_e next_state;
  logic                  flush_pend; // flush seen, burst not yet started
  logic                  start;

  // enough for a full burst, or a pending flush with anything
  assign start = drain_en &&
                 ((num_in_fifo >= burst_pkg::BURST_LEN) ||
                  (flush_pend && (num_in_fifo != '0)));

  always_comb begin
    if (num_in_fifo >= burst_pkg::BURST_LEN)
      len = burst_pkg::BURST_LEN[burst_pkg::LEN_WIDTH-1:0];
    else
      len = num_in_fifo[burst_pkg::LEN_WIDTH-1:0]; // below 8 so it fits
  end

  always_comb begin
    next_state = state;
    case (state)
      burst_pkg::st_idle:
        if (start)
          next_state = burst_pkg::st_cmd;
      burst_pkg::st_cmd:
        next_state = burst_pkg::st_data; // single cycle
      burst_pkg::st_data:
        if (re && last)
          next_state = burst_pkg::st_idle;
      default:
        next_state = burst_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= burst_pkg::st_idle;
      flush_pend <= 1'b0;
    end else if (clear) begin
      state      <= burst_pkg::st_idle;
      flush_pend <= 1'b0;
    end else begin
      state <= next_state;
      if (flush)
        flush_pend <= 1'b1;  // new request wins
      else if (state == burst_pkg::st_idle && start)
        flush_pend <= 1'b0;  // consumed by this burst
    end
  end

  assign cmd_valid  = (state == burst_pkg::st_cmd);
  assign load       = cmd_valid;                          // counter takes len
  assign cmd        = '{addr: addr, len: len};
  assign re         = (state == burst_pkg::st_data) && nempty; // fall through gate
  assign burst_done = re && last;

  // a command never carries an empty burst
  a_cmd_phase : assert property (@(posedge clk) disable iff (rst)
    cmd_valid |-> (cmd.len != '0));

endmodule

/* source/burst_writer.sv */
// memory test write path top
`timescale 1ns/1ps

module burst_writer (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             clear,
  input  logic                             wr_en,
  input  logic [burst_pkg::DATA_WIDTH-1:0] wr_data,
  input  logic                             flush,
  input  logic                             drain_en,
  output logic                             cmd_valid,
  output burst_pkg::mem_cmd_t              cmd,
  output logic                             mem_we,
  output logic [burst_pkg::DATA_WIDTH-1:0] mem_wdata,
  output logic                             burst_done,
  output burst_pkg::fifo_status_t          status
);

  logic [burst_pkg::FILL_WIDTH-1:0] num_in_fifo;
  logic                             nempty;
  logic                             half_full;
  logic                             over;
  logic                             rd_en;    // fifo pop, also memory strobe
  logic                             load;
  logic                             last;
  logic [burst_pkg::LEN_WIDTH-1:0]  len;
  logic [burst_pkg::ADDR_WIDTH-1:0] addr;

  fifo_same_clock_fill fifo0 (
    .clk         (clk),
    .rst         (rst),
    .clear       (clear),
    .we          (wr_en),
    .re          (rd_en),
    .data_in     (wr_data),
    .data_out    (mem_wdata),   // fall through word goes straight out
    .nempty      (nempty),
    .half_full   (half_full),
    .over        (over),
    .num_in_fifo (num_in_fifo)
  );

  burst_counter cnt0 (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .load  (load),
    .step  (rd_en),   // one word per pop
    .len   (len),
    .addr  (addr),
    .last  (last)
  );

  burst_sequencer seq0 (
    .clk         (clk),
    .rst         (rst),
    .clear       (clear),
    .flush       (flush),
    .drain_en    (drain_en),
    .num_in_fifo (num_in_fifo),
    .nempty      (nempty),
    .last        (last),
    .addr        (addr),
    .load        (load),
    .re          (rd_en),
    .len         (len),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .burst_done  (burst_done)
  );

  assign mem_we = rd_en;
  assign status = '{num_in_fifo: num_in_fifo, nempty: nempty,
                    half_full: half_full, over: over};

endmodule

/* verif/mem_model.sv */
// memory write model
`timescale 1ns/1ps

module mem_model (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             cmd_valid,
  input  burst_pkg::mem_cmd_t              cmd,
  input  logic                             mem_we,
  input  logic [burst_pkg::DATA_WIDTH-1:0] mem_wdata,
  input  logic                             burst_done
);

  logic [burst_pkg::DATA_WIDTH-1:0] mem [0:(1 << burst_pkg::ADDR_WIDTH)-1];
  burst_pkg::mem_cmd_t              cmd_q[$];   // commands in arrival order
  logic [burst_pkg::ADDR_WIDTH-1:0] addr_q[$];  // word address per write
  logic [burst_pkg::DATA_WIDTH-1:0] data_q[$];  // word per write
  logic [burst_pkg::ADDR_WIDTH-1:0] base;       // start of open burst
  logic [burst_pkg::ADDR_WIDTH-1:0] offset;     // words taken so far
  logic [burst_pkg::ADDR_WIDTH-1:0] wr_addr;
  int                               remaining;  // words owed by open command
  int                               done_count;
  int                               stray_count; // writes, commands or done pulses out of place

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      base        = '0;
      offset      = '0;
      remaining   = 0;
      done_count  = 0;
      stray_count = 0;
    end else begin
      if (cmd_valid) begin
        if (remaining != 0)
          stray_count++;  // command before old burst finished
        cmd_q.push_back(cmd);
        base      = cmd.addr;
        offset    = '0;
        remaining = cmd.len;
      end
      if (mem_we) begin
        if (remaining == 0)
          stray_count++;  // write with no open command
        else
          remaining--;
        wr_addr      = base + offset; // wraps like the real address
        mem[wr_addr] = mem_wdata;
        addr_q.push_back(wr_addr);
        data_q.push_back(mem_wdata);
        offset++;
      end
      if (burst_done) begin
        if (!mem_we || remaining != 0)
          stray_count++;  // done not with the last word
        done_count++;
      end
    end
  end

endmodule

/* verif/burst_writer_tb.sv */
// burst writer testbench
`timescale 1ns/1ps

module burst_writer_tb;

  localparam int test_cycles     = 1000;            // rough sum over the five tests
  localparam int watchdog_cycles = 2 * test_cycles; // double for margin
  localparam int wait_limit      = 200;             // per burst wait

  logic                             clk;
  logic                             rst;
  logic                             clear;
  logic                             wr_en;
  logic [burst_pkg::DATA_WIDTH-1:0] wr_data;
  logic                             flush;
  logic                             drain_en;
  logic                             cmd_valid;
  burst_pkg::mem_cmd_t              cmd;
  logic                             mem_we;
  logic [burst_pkg::DATA_WIDTH-1:0] mem_wdata;
  logic                             burst_done;
  burst_pkg::fifo_status_t          status;

  logic [31:0]                      lcg_state;
  logic [burst_pkg::DATA_WIDTH-1:0] exp_data[$]; // words due at memory
  logic [burst_pkg::ADDR_WIDTH-1:0] exp_addr[$];
  burst_pkg::mem_cmd_t              exp_cmd[$];
  logic [burst_pkg::ADDR_WIDTH-1:0] next_addr;   // where the next burst lands
  int                               bursts_expected;
  int                               over_count;
  int                               value_errors;
  int                               other_errors;

  burst_writer dut0 (.clk(clk), .rst(rst), .clear(clear), .wr_en(wr_en), .wr_data(wr_data),
                     .flush(flush), .drain_en(drain_en), .cmd_valid(cmd_valid), .cmd(cmd),
                     .mem_we(mem_we), .mem_wdata(mem_wdata), .burst_done(burst_done),
                     .status(status));

  mem_model mem0 (.clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .mem_we(mem_we),
                  .mem_wdata(mem_wdata), .burst_done(burst_done));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (status.over)
      over_count++; // dropped write seen
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #1; // drive and sample away from the edge
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got == exp) else begin
      value_errors++;
      $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      other_errors++;
      $display("%0t: %s", $time, msg);
    end
  endtask

  task automatic write_words(input int n, input logic keep);
    for (int i = 0; i < n; i++) begin
      lcg_state = lcg_next(lcg_state);
      wr_en     = 1'b1;
      wr_data   = lcg_state[31:16]; // upper bits spread better
      if (keep)
        exp_data.push_back(wr_data);
      step_cycle();
    end
    wr_en = 1'b0;
  endtask

  task automatic expect_cmd(input int len);
    exp_cmd.push_back('{addr: next_addr, len: len[burst_pkg::LEN_WIDTH-1:0]});
    for (int i = 0; i < len; i++) begin
      exp_addr.push_back(next_addr);
      next_addr++;
    end
    bursts_expected++;
  endtask

  task automatic wait_bursts(input int target);
    int n;
    n = 0;
    while (mem0.done_count < target && n < wait_limit) begin
      step_cycle();
      n++;
    end
    check_true(mem0.done_count >= target, "timed out waiting for burst_done");
    compare_value("burst_done count", mem0.done_count, target);
  endtask

  task automatic check_cmds();
    burst_pkg::mem_cmd_t got;
    burst_pkg::mem_cmd_t want;
    compare_value("command count", mem0.cmd_q.size(), exp_cmd.size());
    while (exp_cmd.size() > 0 && mem0.cmd_q.size() > 0) begin
      got  = mem0.cmd_q.pop_front();
      want = exp_cmd.pop_front();
      compare_value("cmd.addr", got.addr, want.addr);
      compare_value("cmd.len", got.len, want.len);
    end
    exp_cmd.delete();
    mem0.cmd_q.delete();
  endtask

  task automatic check_writes();
    logic [burst_pkg::ADDR_WIDTH-1:0] a;
    logic [burst_pkg::DATA_WIDTH-1:0] d;
    compare_value("write count", mem0.data_q.size(), exp_data.size());
    while (exp_data.size() > 0 && mem0.data_q.size() > 0) begin
      a = exp_addr.pop_front();
      d = exp_data.pop_front();
      compare_value("mem_wdata", mem0.data_q.pop_front(), d);
      compare_value("write address", mem0.addr_q.pop_front(), a);
      compare_value("memory word", mem0.mem[a], d); // last write there wins
    end
    exp_data.delete();
    exp_addr.delete();
    mem0.data_q.delete();
    mem0.addr_q.delete();
  endtask

  task automatic full_burst();
    drain_en = 1'b1;
    write_words(8, 1'b1);
    expect_cmd(8);
    wait_bursts(bursts_expected);
    check_cmds();
    check_writes();
  endtask

  task automatic flush_burst();
    write_words(3, 1'b1);
    flush = 1'b1;
    step_cycle();
    flush = 1'b0;
    expect_cmd(3);
    wait_bursts(bursts_expected);
    check_cmds();
    check_writes();
  endtask

  task automatic stream_bursts();
    over_count = 0;
    write_words(24, 1'b1); // bursts drain while writing
    expect_cmd(8);
    expect_cmd(8);
    expect_cmd(8);
    wait_bursts(bursts_expected);
    check_cmds();
    check_writes();
    compare_value("over pulses", over_count, 0);
  endtask

  task automatic fill_level();
    drain_en = 1'b0;
    write_words(9, 1'b0); // these never reach memory
    repeat (5) step_cycle();
    compare_value("status.num_in_fifo", status.num_in_fifo, 9);
    compare_value("status.nempty", status.nempty, 1);
    compare_value("status.half_full", status.half_full, 1);
    compare_value("command count", mem0.cmd_q.size(), 0);
  endtask

  task automatic overflow_clear();
    over_count = 0;
    write_words(10, 1'b0); // two past capacity
    repeat (3) step_cycle();
    compare_value("status.num_in_fifo", status.num_in_fifo, burst_pkg::FIFO_WORDS);
    check_true(over_count > 0, "over never pulsed on a full fifo");
    clear = 1'b1;
    step_cycle();
    clear = 1'b0;
    step_cycle();
    compare_value("status.num_in_fifo", status.num_in_fifo, 0);
    compare_value("status.nempty", status.nempty, 0);
    drain_en = 1'b1;
    repeat (20) step_cycle();
    compare_value("command count", mem0.cmd_q.size(), 0);
    compare_value("write count", mem0.data_q.size(), 0);
  endtask

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: run exceeded %0d cycles", watchdog_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst             = 1'b1;
    clear           = 1'b0;
    wr_en           = 1'b0;
    wr_data         = '0;
    flush           = 1'b0;
    drain_en        = 1'b0;
    lcg_state       = 32'hff81;
    next_addr       = '0;
    bursts_expected = 0;
    over_count      = 0;
    value_errors    = 0;
    other_errors    = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    step_cycle();
    full_burst();
    flush_burst();
    stream_bursts();
    fill_level();
    overflow_clear();
    check_true(mem0.stray_count == 0,
               "memory saw a write, command or burst_done out of place");
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* burst_writer.f */
source/burst_pkg.sv
source/fifo_same_clock_fill.sv
source/burst_counter.sv
source/burst_sequencer.sv
source/burst_writer.sv
verif/mem_model.sv
verif/burst_writer_tb.sv
